// ==== hdl/analog_pkg.sv ====
`default_nettype none

package analog_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // converter word widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W = 14; // both ADC and DAC are 14 bit

  // raw pin code, unsigned with negative slope
  typedef logic [SAMPLE_W-1:0] adc_raw_t;

  typedef logic signed [SAMPLE_W-1:0] sample_t; // two's complement sample

  // one guard bit so the sum of two samples cannot wrap
  typedef logic signed [SAMPLE_W:0] sum_t;

  ////////////////////////////////////////////////////////////////////////////
  // two-channel bundles, channel a in the upper half
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    adc_raw_t a; // CH1 raw
    adc_raw_t b; // CH2 raw
  } dual_raw_t;

  typedef struct packed {
    sample_t a; // CH1
    sample_t b; // CH2
  } dual_sample_t;

  // sample zero on the pins: msb kept, rest inverted
  localparam adc_raw_t RAW_ZERO = {1'b0, {(SAMPLE_W-1){1'b1}}};

endpackage : analog_pkg

`default_nettype wire

// ==== hdl/sysbus_pkg.sv ====
`default_nettype none

package sysbus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // system bus words
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] sys_addr_t; // byte address
  typedef logic [31:0] sys_data_t; // read and write data
  typedef logic [3:0]  sys_sel_t;  // byte select, one bit per byte lane

  // master side, strobes are single cycle pulses
  typedef struct packed {
    sys_addr_t addr;  // held until ack
    sys_data_t wdata; // held until ack
    sys_sel_t  sel;
    logic      wen;   // write strobe
    logic      ren;   // read strobe
  } sys_req_t;

  // slave side, all fields valid in the ack cycle
  typedef struct packed {
    sys_data_t rdata;
    logic      err;
    logic      ack;   // one pulse per strobe
  } sys_rsp_t;

  ////////////////////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////////////////////

  localparam int N_REGIONS = 8; // eight equal slices of the address space
  localparam int HK_REGION = 0; // housekeeping lives in the first one

  // housekeeping register offsets inside its region
  localparam sys_addr_t HK_ID_OFS   = 32'h0000_0000; // read only
  localparam sys_addr_t HK_LOOP_OFS = 32'h0000_0004; // bit 0 digital loop
  localparam sys_addr_t HK_LED_OFS  = 32'h0000_0030; // LED bits

  // board identification word
  localparam sys_data_t HK_ID_VALUE = 32'h5250_0014;

endpackage : sysbus_pkg

`default_nettype wire

// ==== hdl/sys_bus_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module sys_bus_decoder #(
  parameter int REGION_LSB = 20   // lowest bit of the region field
) (
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  wire sysbus_pkg::sys_req_t req_i,    // from bus master
  output sysbus_pkg::sys_rsp_t rsp_o,
  output sysbus_pkg::sys_req_t hk_req_o,      // to housekeeping
  input  wire sysbus_pkg::sys_rsp_t hk_rsp_i
);

  localparam int REG_W = $clog2(sysbus_pkg::N_REGIONS); // width of region field

  // keeps only the offset bits below the region field
  localparam sysbus_pkg::sys_addr_t OFS_MASK =
    (sysbus_pkg::sys_addr_t'(1) << REGION_LSB) - 1;

  logic [REG_W-1:0]                 region; // region number from address
  logic [sysbus_pkg::N_REGIONS-1:0] cs;     // one-hot region select
  logic                             strobe; // any access this cycle

  //////////////////////////////////////////////////////////////////////////
  // region select
  //////////////////////////////////////////////////////////////////////////

  assign region = req_i.addr[REGION_LSB +: REG_W];
  assign cs     = {{(sysbus_pkg::N_REGIONS-1){1'b0}}, 1'b1} << region;
  assign strobe = req_i.wen || req_i.ren;

  // strobe steering, slave sees only its offset
  always_comb
  begin
    hk_req_o      = req_i;
    hk_req_o.addr = req_i.addr & OFS_MASK;
    hk_req_o.wen  = req_i.wen && cs[sysbus_pkg::HK_REGION];
    hk_req_o.ren  = req_i.ren && cs[sysbus_pkg::HK_REGION];
  end

  //////////////////////////////////////////////////////////////////////////
  // response multiplexer
  //////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    if (cs[sysbus_pkg::HK_REGION])
    begin
      rsp_o = hk_rsp_i;  // registered answer, one cycle late
    end
    else
    begin
      // empty slot answers at once
      rsp_o.rdata = '0;
      rsp_o.err   = 1'b0;
      rsp_o.ack   = strobe;
    end
  end

  // no slave may answer without an access now or just before
  a_ack_has_strobe : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    rsp_o.ack |-> (strobe || $past(strobe))
  ) else $error("ack without a strobe in this or the previous cycle");

endmodule : sys_bus_decoder

`default_nettype wire

// ==== hdl/hk_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module hk_regs #(
  parameter int LED_W = 8           // number of LED outputs
) (
  input  wire                  adc_clk,
  input  wire                  rst_n_i,
  input  wire sysbus_pkg::sys_req_t req_i,    // offset only, strobes pre-gated
  output sysbus_pkg::sys_rsp_t rsp_o,
  output logic                 digital_loop_o,
  output logic [LED_W-1:0]     led_o
);

  logic                  hit_id;   // offset decode
  logic                  hit_loop;
  logic                  hit_led;
  logic                  hit_any;
  logic                  strobe;
  logic                  wr_ok;    // write with low byte enabled
  sysbus_pkg::sys_data_t rd_mux;   // read-back before the register

  logic                  loop_q;   // digital loop switch
  logic [LED_W-1:0]      led_q;
  logic                  ack_q;
  logic                  err_q;
  sysbus_pkg::sys_data_t rdata_q;

  //////////////////////////////////////////////////////////////////////////
  // offset decode
  //////////////////////////////////////////////////////////////////////////

  assign hit_id   = (req_i.addr == sysbus_pkg::HK_ID_OFS);
  assign hit_loop = (req_i.addr == sysbus_pkg::HK_LOOP_OFS);
  assign hit_led  = (req_i.addr == sysbus_pkg::HK_LED_OFS);
  assign hit_any  = hit_id || hit_loop || hit_led;

  assign strobe = req_i.wen || req_i.ren;
  assign wr_ok  = req_i.wen && req_i.sel[0]; // all fields sit in byte 0

  // read-back, unknown offsets give zero
  always_comb
  begin
    rd_mux = '0;
    if (hit_id)
      rd_mux = sysbus_pkg::HK_ID_VALUE;
    else if (hit_loop)
      rd_mux = sysbus_pkg::sys_data_t'(loop_q);
    else if (hit_led)
      rd_mux = sysbus_pkg::sys_data_t'(led_q);
  end

  //////////////////////////////////////////////////////////////////////////
  // registers and bus handshake
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_q <= 1'b0;
      led_q  <= '0;
      ack_q  <= 1'b0;
      err_q  <= 1'b0;
    end
    else
    begin
      ack_q <= strobe;              // every access answered next cycle
      err_q <= strobe && !hit_any;
      if (wr_ok && hit_loop)
        loop_q <= req_i.wdata[0];
      if (wr_ok && hit_led)
        led_q <= req_i.wdata[LED_W-1:0];
      // ID offset has no write path
    end
  end

  // read data follows the access that caused it
  always_ff @(posedge adc_clk)
  begin
    if (strobe)
      rdata_q <= rd_mux;
  end

  assign rsp_o = '{rdata: rdata_q, err: err_q, ack: ack_q};

  assign digital_loop_o = loop_q;
  assign led_o          = led_q;

  // master issues one access at a time
  a_no_dual_strobe : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    !(req_i.wen && req_i.ren)
  ) else $error("write and read strobe raised together");

endmodule : hk_regs

`default_nettype wire

// ==== hdl/adc_frontend.sv ====
`default_nettype none
`timescale 1ns/1ps

module adc_frontend (
  input  wire                            adc_clk,
  input  wire                            rst_n_i,
  input  wire analog_pkg::dual_raw_t     adc_dat_i,      // converter bits 15:2
  input  wire analog_pkg::dual_sample_t  loop_dat_i,     // DAC side, same cycle
  input  wire                            digital_loop_i,
  output analog_pkg::dual_sample_t       adc_o
);

  analog_pkg::dual_raw_t    raw_q;  // input registers
  analog_pkg::dual_sample_t conv;   // after code conversion

  // negative slope code to two's complement
  function automatic analog_pkg::sample_t raw_to_sample(
    input analog_pkg::adc_raw_t raw
  );
    return {raw[analog_pkg::SAMPLE_W-1], ~raw[analog_pkg::SAMPLE_W-2:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////////////////////////////

  // ideally packed into the IO block flops
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      raw_q <= '0;
    end
    else
    begin
      raw_q <= adc_dat_i;
    end
  end

  assign conv.a = raw_to_sample(raw_q.a);
  assign conv.b = raw_to_sample(raw_q.b);

  //////////////////////////////////////////////////////////////////////////
  // loopback select
  //////////////////////////////////////////////////////////////////////////

  // loop path bypasses the capture register
  always_comb
  begin
    if (digital_loop_i)
      adc_o = loop_dat_i;
    else
      adc_o = conv;
  end

endmodule : adc_frontend

`default_nettype wire

// ==== hdl/dac_mixer.sv ====
`default_nettype none
`timescale 1ns/1ps

module dac_mixer (
  input  wire                            adc_clk,
  input  wire                            rst_n_i,
  input  wire analog_pkg::dual_sample_t  asg_i,      // generator
  input  wire analog_pkg::dual_sample_t  pid_i,      // controller
  output analog_pkg::dual_sample_t       mix_o,      // saturated, unregistered
  output analog_pkg::dual_raw_t          dac_dat_o
);

  analog_pkg::sum_t      sum_a;  // full width sums
  analog_pkg::sum_t      sum_b;
  analog_pkg::dual_raw_t dac_q;

  // clip to 14 bits when the guard bit disagrees with the sign
  function automatic analog_pkg::sample_t saturate(input analog_pkg::sum_t s);
    if (s[analog_pkg::SAMPLE_W] ^ s[analog_pkg::SAMPLE_W-1])
      return {s[analog_pkg::SAMPLE_W], {(analog_pkg::SAMPLE_W-1){~s[analog_pkg::SAMPLE_W]}}};
    return s[analog_pkg::SAMPLE_W-1:0];
  endfunction

  // back to the pin code, msb kept and rest inverted
  function automatic analog_pkg::adc_raw_t sample_to_raw(input analog_pkg::sample_t d);
    return {d[analog_pkg::SAMPLE_W-1], ~d[analog_pkg::SAMPLE_W-2:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////////////////

  assign sum_a = analog_pkg::sum_t'(asg_i.a) + analog_pkg::sum_t'(pid_i.a); // sign extended
  assign sum_b = analog_pkg::sum_t'(asg_i.b) + analog_pkg::sum_t'(pid_i.b);

  assign mix_o.a = saturate(sum_a);
  assign mix_o.b = saturate(sum_b);

  //////////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_q.a <= analog_pkg::RAW_ZERO; // mid scale, no output swing
      dac_q.b <= analog_pkg::RAW_ZERO;
    end
    else
    begin
      dac_q.a <= sample_to_raw(mix_o.a);
      dac_q.b <= sample_to_raw(mix_o.b);
    end
  end

  assign dac_dat_o = dac_q;

  // in-range sums pass untouched on both channels
  a_no_false_clip : assert property (
    @(posedge adc_clk) disable iff (!rst_n_i)
    ((sum_a[analog_pkg::SAMPLE_W] == sum_a[analog_pkg::SAMPLE_W-1])
      |-> (analog_pkg::sum_t'(mix_o.a) == sum_a)) and
    ((sum_b[analog_pkg::SAMPLE_W] == sum_b[analog_pkg::SAMPLE_W-1])
      |-> (analog_pkg::sum_t'(mix_o.b) == sum_b))
  ) else $error("mixer output differs from an in-range sum");

endmodule : dac_mixer

`default_nettype wire

// ==== hdl/analog_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module analog_top #(
  parameter int REGION_LSB = 20, // region field is addr[22:20]
  parameter int LED_W      = 8
) (
  input  wire                            adc_clk,
  input  wire                            rst_n_i,
  // system bus
  input  wire sysbus_pkg::sys_req_t      sys_req_i,
  output sysbus_pkg::sys_rsp_t           sys_rsp_o,
  // converters
  input  wire analog_pkg::dual_raw_t     adc_dat_i,  // ADC pins, low bits dropped
  input  wire analog_pkg::dual_sample_t  asg_i,      // generator samples
  input  wire analog_pkg::dual_sample_t  pid_i,      // controller samples
  output analog_pkg::dual_sample_t       adc_o,
  output analog_pkg::dual_raw_t          dac_dat_o,  // DAC pins
  // LED
  output logic [LED_W-1:0]               led_o
);

  sysbus_pkg::sys_req_t     hk_req;       // region 0 request
  sysbus_pkg::sys_rsp_t     hk_rsp;
  logic                     digital_loop; // ADC takes DAC value when set
  analog_pkg::dual_sample_t mix;          // saturated DAC value

  ////////////////////////////////////////////////////////////////////////////
  // bus decoder and housekeeping
  ////////////////////////////////////////////////////////////////////////////

  sys_bus_decoder #(
    .REGION_LSB (REGION_LSB)
  ) i_dec (
    .adc_clk  (adc_clk),
    .rst_n_i  (rst_n_i),
    .req_i    (sys_req_i),
    .rsp_o    (sys_rsp_o),
    .hk_req_o (hk_req),
    .hk_rsp_i (hk_rsp)
  );

  hk_regs #(
    .LED_W (LED_W)
  ) i_hk (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .req_i          (hk_req),
    .rsp_o          (hk_rsp),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapaths
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_i      (adc_dat_i),
    .loop_dat_i     (mix),          // combinational loop path
    .digital_loop_i (digital_loop),
    .adc_o          (adc_o)
  );

  dac_mixer i_dac (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .asg_i     (asg_i),
    .pid_i     (pid_i),
    .mix_o     (mix),
    .dac_dat_o (dac_dat_o)
  );

endmodule : analog_top

`default_nettype wire

// ==== testbench/tb_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_checker #(
  parameter int LED_W = 8
) (
  input  wire                            adc_clk,
  input  wire                            rst_n_i,
  input  wire sysbus_pkg::sys_req_t      sys_req_i,
  input  wire sysbus_pkg::sys_rsp_t      sys_rsp_i,
  input  wire analog_pkg::dual_raw_t     adc_dat_i,
  input  wire analog_pkg::dual_sample_t  asg_i,
  input  wire analog_pkg::dual_sample_t  pid_i,
  input  wire analog_pkg::dual_sample_t  adc_i,      // DUT adc_o
  input  wire analog_pkg::dual_raw_t     dac_dat_i,  // DUT dac_dat_o
  input  wire [LED_W-1:0]                led_i,
  output int                             checks_o,
  output int                             errors_o
);

  logic                     m_loop;       // model of the loop switch
  logic [LED_W-1:0]         m_led;
  analog_pkg::dual_raw_t    prev_raw;     // last cycle's ADC pins
  analog_pkg::dual_sample_t prev_mix;     // last cycle's clipped sum
  analog_pkg::dual_sample_t exp_mix;
  analog_pkg::dual_sample_t exp_adc;
  logic                     hk_pend;      // housekeeping ack due now
  logic                     hk_pend_rd;
  logic                     hk_pend_err;
  sysbus_pkg::sys_data_t    hk_pend_data;
  logic                     strobe;
  logic [2:0]               region;       // addr[22:20]
  sysbus_pkg::sys_addr_t    ofs;
  int                       tot_checks = 0;
  int                       tot_errors = 0;
  int                       base_checks = 0;
  int                       base_errors = 0;

  // pin code and sample differ only in the lower 13 bits
  function automatic logic [13:0] flip_code(input logic [13:0] c);
    return c ^ 14'h1fff;
  endfunction

  // integer sum clamped to the 14-bit range
  function automatic analog_pkg::sample_t clip_sum(input analog_pkg::sample_t x,
                                                    input analog_pkg::sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return analog_pkg::sample_t'(s);
  endfunction

  function automatic sysbus_pkg::sys_data_t hk_read(input sysbus_pkg::sys_addr_t a);
    case (a)
      sysbus_pkg::HK_ID_OFS:   return sysbus_pkg::HK_ID_VALUE;
      sysbus_pkg::HK_LOOP_OFS: return {31'b0, m_loop};
      sysbus_pkg::HK_LED_OFS:  return 32'(m_led);
      default:                 return '0; // unknown offset
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    tot_checks++;
    if (got !== exp)
    begin
      tot_errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // per-test summary, counts since the previous call
  task automatic report_test(input string name);
    $display("test %-16s %0d checks, %0d mismatches", name,
             tot_checks - base_checks, tot_errors - base_errors);
    base_checks = tot_checks;
    base_errors = tot_errors;
  endtask

  assign checks_o = tot_checks;
  assign errors_o = tot_errors;

  //////////////////////////////////////////////////////////////////////////
  // compare at the falling edge, everything settled there
  //////////////////////////////////////////////////////////////////////////

  always @(negedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      m_loop   = 1'b0; // reset image of the DUT
      m_led    = '0;
      prev_raw = '0;
      prev_mix = '0;   // codes to RAW_ZERO
      hk_pend  = 1'b0;
    end
    else
    begin
      exp_mix.a = clip_sum(asg_i.a, pid_i.a);
      exp_mix.b = clip_sum(asg_i.b, pid_i.b);
      if (m_loop)
        exp_adc = exp_mix;                    // same cycle, no register
      else
        exp_adc = {flip_code(prev_raw.a), flip_code(prev_raw.b)};
      compare("adc_o.a", adc_i.a, exp_adc.a);
      compare("adc_o.b", adc_i.b, exp_adc.b);
      compare("dac_dat_o.a", dac_dat_i.a, flip_code(prev_mix.a));
      compare("dac_dat_o.b", dac_dat_i.b, flip_code(prev_mix.b));
      compare("led_o", led_i, m_led);

      // bus response
      strobe = sys_req_i.wen || sys_req_i.ren;
      region = sys_req_i.addr[22:20];
      ofs    = sys_req_i.addr & 32'h000f_ffff;
      compare("ack", sys_rsp_i.ack, hk_pend || (strobe && region != 0));
      if (hk_pend)
      begin
        compare("err", sys_rsp_i.err, hk_pend_err);
        if (hk_pend_rd)
          compare("rdata", sys_rsp_i.rdata, hk_pend_data);
      end
      else if (strobe && region != 0)
      begin
        compare("err", sys_rsp_i.err, 1'b0);    // empty region
        compare("rdata", sys_rsp_i.rdata, '0);
      end

      // new housekeeping access, answered next cycle
      hk_pend = strobe && (region == sysbus_pkg::HK_REGION);
      if (hk_pend)
      begin
        hk_pend_rd   = sys_req_i.ren;
        hk_pend_err  = !(ofs == sysbus_pkg::HK_ID_OFS || ofs == sysbus_pkg::HK_LOOP_OFS ||
                         ofs == sysbus_pkg::HK_LED_OFS);
        hk_pend_data = hk_read(ofs);
        if (sys_req_i.wen && sys_req_i.sel[0])
        begin
          if (ofs == sysbus_pkg::HK_LOOP_OFS)
            m_loop = sys_req_i.wdata[0];
          else if (ofs == sysbus_pkg::HK_LED_OFS)
            m_led = sys_req_i.wdata[LED_W-1:0];
        end
      end
      prev_raw = adc_dat_i;
      prev_mix = exp_mix;
    end
  end

endmodule : tb_checker

`default_nettype wire

// ==== testbench/tb_analog_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_analog_top;

  localparam int LED_W      = 8;
  localparam int RST_CYCLES = 16;
  localparam int N_ADC      = 1000; // cycles
  localparam int N_DAC      = 1000;
  localparam int N_LOOP     = 1000;
  localparam int N_REG      = 75;   // rounds of four accesses
  localparam int N_DEC      = 75;   // rounds of five accesses
  localparam int ACC_CYCLES = 4;    // worst case for one access
  localparam int TIMEOUT    = 2 * (RST_CYCLES + N_ADC + N_DAC + N_LOOP + 40 +
                                   ACC_CYCLES * (4 * N_REG + 5 * N_DEC + 4));

  logic                     adc_clk;
  logic                     rst_n;
  sysbus_pkg::sys_req_t     sys_req;
  sysbus_pkg::sys_rsp_t     sys_rsp;
  analog_pkg::dual_raw_t    adc_dat;
  analog_pkg::dual_sample_t asg;
  analog_pkg::dual_sample_t pid;
  analog_pkg::dual_sample_t adc;
  analog_pkg::dual_raw_t    dac_dat;
  logic [LED_W-1:0]         led;
  int                       seed;
  int                       cycles = 0;
  int                       checks;
  int                       errors;
  logic [31:0]              r;

  analog_top #(.REGION_LSB(20), .LED_W(LED_W)) dut0 (
    .adc_clk (adc_clk), .rst_n_i (rst_n), .sys_req_i (sys_req), .sys_rsp_o (sys_rsp),
    .adc_dat_i (adc_dat), .asg_i (asg), .pid_i (pid), .adc_o (adc),
    .dac_dat_o (dac_dat), .led_o (led)
  );

  tb_checker #(.LED_W(LED_W)) chk0 (
    .adc_clk (adc_clk), .rst_n_i (rst_n), .sys_req_i (sys_req), .sys_rsp_i (sys_rsp),
    .adc_dat_i (adc_dat), .asg_i (asg), .pid_i (pid), .adc_i (adc),
    .dac_dat_i (dac_dat), .led_i (led), .checks_o (checks), .errors_o (errors)
  );

  always #4 adc_clk = ~adc_clk; // 125 MHz

  // hang guard
  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////////

  task automatic step(); // drive point 1 ns after the rising edge
    @(posedge adc_clk);
    #1;
  endtask

  // one strobe with the address held until ack
  task automatic bus_access(input sysbus_pkg::sys_addr_t addr, input sysbus_pkg::sys_data_t wdata,
                            input sysbus_pkg::sys_sel_t sel, input logic write);
    step();
    sys_req = '{addr: addr, wdata: wdata, sel: sel, wen: write, ren: !write};
    @(negedge adc_clk);
    while (!sys_rsp.ack)
    begin
      step();
      sys_req.wen = 1'b0; // single cycle pulse
      sys_req.ren = 1'b0;
      @(negedge adc_clk);
    end
    step();
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
  endtask

  task automatic bus_write(input sysbus_pkg::sys_addr_t addr, input sysbus_pkg::sys_data_t wdata,
                           input sysbus_pkg::sys_sel_t sel);
    bus_access(addr, wdata, sel, 1'b1);
  endtask

  task automatic bus_read(input sysbus_pkg::sys_addr_t addr);
    bus_access(addr, '0, 4'hf, 1'b0);
  endtask

  // random address in regions 1 to 7 with the LED offset half the time
  function automatic sysbus_pkg::sys_addr_t other_region_addr();
    logic [31:0] a;
    logic [19:0] ofs;
    int          reg_n;
    a     = $random(seed);
    reg_n = $unsigned($random(seed)) % 7 + 1;
    ofs   = a[20] ? 20'(sysbus_pkg::HK_LED_OFS) : a[19:0];
    return {a[31:23], 3'(reg_n), ofs};
  endfunction

  function automatic sysbus_pkg::sys_addr_t unknown_ofs_addr(); // bit 8 set so never a register
    logic [31:0] a;
    a = $random(seed);
    return {a[31:23], 3'd0, a[19:0] | 20'h00100};
  endfunction

  function automatic analog_pkg::sample_t full_scale(input logic neg);
    return neg ? 14'h2000 : 14'h1fff;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////////

  initial
  begin
    seed    = 32'h3beddbe9;
    adc_clk = 1'b0;
    rst_n   = 1'b0;
    sys_req = '0;
    adc_dat = '0;
    asg     = '0;
    pid     = '0;
    repeat (RST_CYCLES) @(posedge adc_clk);
    #1 rst_n = 1'b1;
    repeat (4) step();

    repeat (N_ADC) // raw words through the capture path
    begin
      step();
      r       = $random(seed);
      adc_dat = r[27:0];
    end
    repeat (2) step();
    chk0.report_test("adc conversion");

    repeat (N_DAC)
    begin
      step();
      r   = $random(seed);
      asg = r[27:0];
      r   = $random(seed);
      pid = r[27:0];
      r   = $random(seed);
      if (r[2:0] == 3'd0) // full scale corner
      begin
        asg.a = full_scale(r[8]);
        asg.b = full_scale(r[9]);
        pid.a = full_scale(r[10]);
        pid.b = full_scale(r[11]);
      end
    end
    repeat (2) step();
    chk0.report_test("dac mixing");

    bus_write(sysbus_pkg::HK_LOOP_OFS, 32'h1, 4'hf);
    repeat (N_LOOP)
    begin
      step();
      r       = $random(seed);
      adc_dat = r[27:0]; // must be ignored now
      r       = $random(seed);
      asg     = r[27:0];
      r       = $random(seed);
      pid     = r[27:0];
    end
    bus_read(sysbus_pkg::HK_LOOP_OFS);
    bus_write(sysbus_pkg::HK_LOOP_OFS, 32'h0, 4'h1);
    repeat (16) // ADC path back
    begin
      step();
      r       = $random(seed);
      adc_dat = r[27:0];
    end
    repeat (2) step();
    chk0.report_test("loopback");

    repeat (N_REG)
    begin
      r = $random(seed);
      bus_write(sysbus_pkg::HK_LED_OFS, $random(seed), r[3:0]); // sel[0] clear half the time
      bus_read(sysbus_pkg::HK_LED_OFS);
      bus_write(sysbus_pkg::HK_ID_OFS, $random(seed), 4'hf);
      bus_read(sysbus_pkg::HK_ID_OFS);
    end
    repeat (2) step();
    chk0.report_test("register access");

    repeat (N_DEC)
    begin
      bus_write(other_region_addr(), $random(seed), 4'hf);
      bus_read(other_region_addr());
      bus_read(unknown_ofs_addr());
      bus_write(unknown_ofs_addr(), $random(seed), 4'hf);
      bus_read(sysbus_pkg::HK_LED_OFS); // state left alone
    end
    repeat (2) step();
    chk0.report_test("decoding");

    $display("5 tests, %0d checks, %0d mismatches", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule : tb_analog_top

`default_nettype wire

// ==== sources.f ====
hdl/analog_pkg.sv
hdl/sysbus_pkg.sv
hdl/sys_bus_decoder.sv
hdl/hk_regs.sv
hdl/adc_frontend.sv
hdl/dac_mixer.sv
hdl/analog_top.sv
testbench/tb_checker.sv
testbench/tb_analog_top.sv
